/* logic/ooo_pkg.sv */
package ooo_pkg;

  localparam int data_width = 16;
  localparam int tag_width  = 4;  // Tag 0 is "no tag"

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_mul
  } fu_op_t;

  typedef enum logic {
    class_alu,
    class_mul
  } fu_class_t;

  // Operand still waiting on a producer
  typedef struct packed {
    logic [data_width-tag_width-1:0] pad;
    logic [tag_width-1:0]            tag;
  } wait_word_t;

  typedef union packed {
    logic [data_width-1:0] value;  // Valid once ready
    wait_word_t            wait_on;
  } operand_t;

  typedef struct packed {
    logic     ready;
    operand_t word;
  } src_t;

  typedef struct packed {
    logic                 busy;
    fu_op_t               op;
    logic [tag_width-1:0] dest_tag;
    src_t                 src1;
    src_t                 src2;
  } rs_entry_t;

  function automatic fu_class_t op_class(fu_op_t op);
    return (op == op_mul) ? class_mul : class_alu;
  endfunction

endpackage

/* logic/fu_issue_if.sv */
`timescale 1ns/1ps

interface fu_issue_if import ooo_pkg::*; ();

  logic                  valid;
  fu_op_t                op;
  logic [tag_width-1:0]  dest_tag;
  logic [data_width-1:0] src1_value;
  logic [data_width-1:0] src2_value;
  logic                  accept;  // Unit can take an op this cycle

  modport station (
    output valid, op, dest_tag, src1_value, src2_value,
    input  accept
  );

  modport unit (
    input  valid, op, dest_tag, src1_value, src2_value,
    output accept
  );

endinterface

/* logic/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; #(
  parameter int alu_entries = 4,
  parameter int mul_entries = 2
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  fu_op_t                dispatch_op,
  input  logic [tag_width-1:0]  dispatch_tag,
  input  logic                  src1_ready,
  input  operand_t              src1_word,
  input  logic                  src2_ready,
  input  operand_t              src2_word,
  output logic                  dispatch_ready,
  input  logic                  cdb_valid,
  input  logic [tag_width-1:0]  cdb_tag,
  input  logic [data_width-1:0] cdb_value,
  fu_issue_if.station           alu_issue,
  fu_issue_if.station           mul_issue
);

  localparam int num_entries = alu_entries + mul_entries;
  localparam int idx_width   = $clog2(num_entries);

  rs_entry_t [num_entries-1:0] entries;
  rs_entry_t [num_entries-1:0] next_entries;
  logic      [num_entries-1:0] entry_ready;
  logic      [idx_width-1:0]   alu_pick;
  logic      [idx_width-1:0]   mul_pick;
  logic      [idx_width-1:0]   free_pick;
  logic                        alu_hit;
  logic                        mul_hit;
  logic                        free_hit;
  fu_class_t                   dispatch_class;

  // ALU entries first, multiplier entries above them
  function automatic fu_class_t entry_class(int i);
    return (i < alu_entries) ? class_alu : class_mul;
  endfunction

  function automatic src_t wake(
    src_t                  src,
    logic                  bus_valid,
    logic [tag_width-1:0]  bus_tag,
    logic [data_width-1:0] bus_value
  );
    src_t woken;
    woken = src;
    if (!src.ready && bus_valid && src.word.wait_on.tag == bus_tag) begin
      woken.ready      = 1'b1;
      woken.word.value = bus_value;  // Tag word becomes the value
    end
    return woken;
  endfunction

  always_comb begin
    for (int i = 0; i < num_entries; i++) begin
      entry_ready[i] = entries[i].busy && entries[i].src1.ready && entries[i].src2.ready;
    end
  end

  // Descending scan so the lowest index wins
  always_comb begin
    alu_hit  = 1'b0;
    alu_pick = '0;
    mul_hit  = 1'b0;
    mul_pick = '0;
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (entry_ready[i]) begin
        if (entry_class(i) == class_alu) begin
          alu_hit  = 1'b1;
          alu_pick = idx_width'(i);
        end else begin
          mul_hit  = 1'b1;
          mul_pick = idx_width'(i);
        end
      end
    end
  end

  assign alu_issue.valid      = alu_hit;
  assign alu_issue.op         = entries[alu_pick].op;
  assign alu_issue.dest_tag   = entries[alu_pick].dest_tag;
  assign alu_issue.src1_value = entries[alu_pick].src1.word.value;
  assign alu_issue.src2_value = entries[alu_pick].src2.word.value;

  assign mul_issue.valid      = mul_hit;
  assign mul_issue.op         = entries[mul_pick].op;
  assign mul_issue.dest_tag   = entries[mul_pick].dest_tag;
  assign mul_issue.src1_value = entries[mul_pick].src1.word.value;
  assign mul_issue.src2_value = entries[mul_pick].src2.word.value;

  assign dispatch_class = op_class(dispatch_op);

  // Entries freed this cycle are not offered until the next one
  always_comb begin
    free_hit  = 1'b0;
    free_pick = '0;
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (!entries[i].busy && entry_class(i) == dispatch_class) begin
        free_hit  = 1'b1;
        free_pick = idx_width'(i);
      end
    end
  end

  assign dispatch_ready = free_hit;

  always_comb begin
    src_t disp_src1;
    src_t disp_src2;
    disp_src1.ready = src1_ready;
    disp_src1.word  = src1_word;
    disp_src2.ready = src2_ready;
    disp_src2.word  = src2_word;
    next_entries    = entries;
    for (int i = 0; i < num_entries; i++) begin
      next_entries[i].src1 = wake(entries[i].src1, cdb_valid, cdb_tag, cdb_value);
      next_entries[i].src2 = wake(entries[i].src2, cdb_valid, cdb_tag, cdb_value);
    end
    if (alu_issue.valid && alu_issue.accept) next_entries[alu_pick].busy = 1'b0;
    if (mul_issue.valid && mul_issue.accept) next_entries[mul_pick].busy = 1'b0;
    if (dispatch_valid && dispatch_ready) begin
      next_entries[free_pick].busy     = 1'b1;
      next_entries[free_pick].op       = dispatch_op;
      next_entries[free_pick].dest_tag = dispatch_tag;
      // Catch a broadcast in the dispatch cycle itself
      next_entries[free_pick].src1 = wake(disp_src1, cdb_valid, cdb_tag, cdb_value);
      next_entries[free_pick].src2 = wake(disp_src2, cdb_valid, cdb_tag, cdb_value);
    end
  end

  always_ff @(posedge clock) begin
    entries <= next_entries;
    if (reset) begin
      for (int i = 0; i < num_entries; i++) begin
        entries[i].busy <= 1'b0;
      end
    end
  end

endmodule

/* logic/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import ooo_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  fu_issue_if.unit              issue,
  input  logic                  alu_grant,
  output logic                  alu_result_valid,
  output logic [tag_width-1:0]  alu_result_tag,
  output logic [data_width-1:0] alu_result_value
);

  logic [data_width-1:0] result;
  logic                  take;

  always_comb begin
    case (issue.op)
      op_add:  result = issue.src1_value + issue.src2_value;
      op_sub:  result = issue.src1_value - issue.src2_value;
      op_and:  result = issue.src1_value & issue.src2_value;
      op_xor:  result = issue.src1_value ^ issue.src2_value;
      default: result = '0;  // Multiplies never come here
    endcase
  end

  // Room when empty or draining onto the bus now
  assign issue.accept = !alu_result_valid || alu_grant;
  assign take         = issue.valid && issue.accept;

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result_valid <= 1'b0;
    end else if (take) begin
      alu_result_valid <= 1'b1;
    end else if (alu_grant) begin
      alu_result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      alu_result_tag   <= issue.dest_tag;
      alu_result_value <= result;
    end
  end

endmodule

/* logic/mult_unit.sv */
`timescale 1ns/1ps

module mult_unit import ooo_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  fu_issue_if.unit              issue,
  output logic                  mul_result_valid,
  output logic [tag_width-1:0]  mul_result_tag,
  output logic [data_width-1:0] mul_result_value
);

  localparam int half = data_width / 2;

  logic [3:0]                valid_q;
  logic [3:0][tag_width-1:0] tag_q;
  logic [data_width-1:0]     a_q;
  logic [data_width-1:0]     b_q;
  logic [data_width-1:0]     low_prod;   // al * bl
  logic [half-1:0]           cross_hi;   // ah * bl, low byte only
  logic [half-1:0]           cross_lo;   // al * bh, low byte only
  logic [data_width-1:0]     low_prod_q;
  logic [half-1:0]           cross_sum;

  assign issue.accept = 1'b1;  // Fully pipelined

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[2:0], issue.valid};
    end
  end

  always_ff @(posedge clock) begin
    tag_q <= {tag_q[2:0], issue.dest_tag};
    a_q   <= issue.src1_value;
    b_q   <= issue.src2_value;
    // Partial products
    low_prod <= a_q[half-1:0] * b_q[half-1:0];
    cross_hi <= half'(a_q[data_width-1:half] * b_q[half-1:0]);
    cross_lo <= half'(a_q[half-1:0] * b_q[data_width-1:half]);
    // Fold cross terms
    low_prod_q <= low_prod;
    cross_sum  <= cross_hi + cross_lo;
    mul_result_value <= low_prod_q + {cross_sum, {half{1'b0}}};
  end

  assign mul_result_valid = valid_q[3];
  assign mul_result_tag   = tag_q[3];

endmodule

/* logic/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter import ooo_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alu_result_valid,
  input  logic [tag_width-1:0]  alu_result_tag,
  input  logic [data_width-1:0] alu_result_value,
  input  logic                  mul_result_valid,
  input  logic [tag_width-1:0]  mul_result_tag,
  input  logic [data_width-1:0] mul_result_value,
  output logic                  alu_grant,
  output logic                  cdb_valid,
  output logic [tag_width-1:0]  cdb_tag,
  output logic [data_width-1:0] cdb_value
);

  // Multiplier cannot stall, so it always wins
  assign alu_grant = alu_result_valid && !mul_result_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= mul_result_valid || alu_result_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mul_result_valid) begin
      cdb_tag   <= mul_result_tag;
      cdb_value <= mul_result_value;
    end else if (alu_result_valid) begin
      cdb_tag   <= alu_result_tag;
      cdb_value <= alu_result_value;
    end
  end

endmodule

/* logic/issue_core.sv */
`timescale 1ns/1ps

module issue_core import ooo_pkg::*; #(
  parameter int alu_entries = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  fu_op_t                dispatch_op,
  input  logic [tag_width-1:0]  dispatch_tag,
  input  logic                  src1_ready,
  input  operand_t              src1_word,
  input  logic                  src2_ready,
  input  operand_t              src2_word,
  output logic                  dispatch_ready,
  output logic                  cdb_valid,
  output logic [tag_width-1:0]  cdb_tag,
  output logic [data_width-1:0] cdb_value
);

  logic                  alu_result_valid;
  logic [tag_width-1:0]  alu_result_tag;
  logic [data_width-1:0] alu_result_value;
  logic                  mul_result_valid;
  logic [tag_width-1:0]  mul_result_tag;
  logic [data_width-1:0] mul_result_value;
  logic                  alu_grant;

  fu_issue_if alu_if ();
  fu_issue_if mul_if ();

  reservation_station #(
    .alu_entries(alu_entries)
  ) rs_inst (
    .clock, .reset,
    .dispatch_valid, .dispatch_op, .dispatch_tag,
    .src1_ready, .src1_word, .src2_ready, .src2_word,
    .dispatch_ready,
    .cdb_valid, .cdb_tag, .cdb_value,  // Wakeup from the bus
    .alu_issue(alu_if.station),
    .mul_issue(mul_if.station)
  );

  alu_unit alu_inst (
    .clock, .reset,
    .issue(alu_if.unit),
    .alu_grant,
    .alu_result_valid, .alu_result_tag, .alu_result_value
  );

  mult_unit mul_inst (
    .clock, .reset,
    .issue(mul_if.unit),
    .mul_result_valid, .mul_result_tag, .mul_result_value
  );

  cdb_arbiter arb_inst (
    .clock, .reset,
    .alu_result_valid, .alu_result_tag, .alu_result_value,
    .mul_result_valid, .mul_result_tag, .mul_result_value,
    .alu_grant,
    .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

/* dv/issue_core_tb.sv */
`timescale 1ns/1ps

module issue_core_tb import ooo_pkg::*; ();

  localparam int max_lines         = 64;
  localparam int fields            = 8;
  localparam int backpressure_test = 6;
  localparam int cycles_per_line   = 50;

  logic                  clock;
  logic                  reset;
  logic                  dispatch_valid;
  fu_op_t                dispatch_op;
  logic [tag_width-1:0]  dispatch_tag;
  logic                  src1_ready;
  operand_t              src1_word;
  logic                  src2_ready;
  operand_t              src2_word;
  logic                  dispatch_ready;
  logic                  cdb_valid;
  logic [tag_width-1:0]  cdb_tag;
  logic [data_width-1:0] cdb_value;

  logic [15:0]           stim [0:max_lines*fields-1];
  logic [15:0]           pending;  // One bit per tag still owed by the bus
  logic [data_width-1:0] expected [16];
  int                    num_lines;
  int                    error_count;
  int                    tests_passed;
  int                    tests_failed;

  issue_core #(.alu_entries(4)) issue_core_inst (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic check(
    input logic [data_width-1:0] actual,
    input logic [data_width-1:0] wanted,
    input string                 what
  );
    if (actual !== wanted) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, wanted);
      error_count++;
    end
  endtask

  // Every cycle of the run passes through here at the falling edge
  task automatic sample_bus();
    @(negedge clock);
    if (cdb_valid) begin
      if (!pending[cdb_tag]) begin
        $display("Bus result for tag %0d at %0t ns was not expected or already retired",
                 cdb_tag, $time);
        error_count++;
      end else begin
        check(cdb_value, expected[cdb_tag], $sformatf("bus value for tag %0d", cdb_tag));
        pending[cdb_tag] = 1'b0;
      end
    end
  endtask

  task automatic dispatch_line(input int line, inout int stalls);
    int base;
    base           = line * fields;
    dispatch_valid = 1'b1;
    dispatch_op    = fu_op_t'(stim[base+1][2:0]);
    dispatch_tag   = stim[base+2][tag_width-1:0];
    src1_ready     = stim[base+3][0];
    src1_word      = stim[base+4];
    src2_ready     = stim[base+5][0];
    src2_word      = stim[base+6];
    sample_bus();
    while (!dispatch_ready) begin
      stalls++;
      sample_bus();
    end
    pending[dispatch_tag]  = 1'b1;  // Taken at the coming edge
    expected[dispatch_tag] = stim[base+7];
    @(posedge clock);
    #2;
    dispatch_valid = 1'b0;
  endtask

  task automatic report_test(input logic [15:0] id, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("Test %0d: passed", id);
    end else begin
      tests_failed++;
      $display("Test %0d: %0d errors", id, error_count - errors_before);
    end
  endtask

  initial begin
    int          first;
    int          line;
    int          stalls;
    int          errors_before;
    logic [15:0] test_id;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op    = op_add;
    dispatch_tag   = '0;
    src1_ready     = 1'b0;
    src1_word      = '0;
    src2_ready     = 1'b0;
    src2_word      = '0;
    pending        = '0;
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    num_lines      = 0;
    for (int i = 0; i < max_lines * fields; i++) begin
      stim[i] = 16'hffff;  // End marker where the file stops
    end
    $readmemh("dv/issue_input.txt", stim);
    while (num_lines < max_lines && stim[num_lines*fields] != 16'hffff) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("No stimulus lines found in dv/issue_input.txt");
      error_count++;
    end
    repeat (10) @(posedge clock);
    #2;
    reset = 1'b0;

    // Reset state
    errors_before = error_count;
    dispatch_op   = op_add;
    sample_bus();
    check(16'(cdb_valid), 16'd0, "bus idle after reset");
    check(16'(dispatch_ready), 16'd1, "ALU entry free after reset");
    @(posedge clock);
    #2;
    dispatch_op = op_mul;
    sample_bus();
    check(16'(dispatch_ready), 16'd1, "multiplier entry free after reset");
    report_test(16'd1, errors_before);
    @(posedge clock);
    #2;

    first = 0;
    while (first < num_lines) begin
      test_id       = stim[first*fields];
      errors_before = error_count;
      stalls        = 0;
      line          = first;
      while (line < num_lines && stim[line*fields] == test_id) begin
        dispatch_line(line, stalls);
        line++;
      end
      while (pending != '0) begin
        sample_bus();
      end
      if (test_id == 16'(backpressure_test)) begin
        check(16'(stalls > 0), 16'd1, "ALU dispatch held off while entries wait");
      end
      report_test(test_id, errors_before);
      @(posedge clock);
      #2;
      first = line;
    end

    repeat (5) sample_bus();  // Catch late duplicates
    $display("Tests passed: %0d, failed: %0d, check errors: %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (num_lines > 0);
    repeat (num_lines * cycles_per_line + 20) @(posedge clock);
    $display("Timeout: results still missing after %0d cycles",
             num_lines * cycles_per_line + 20);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* dv/issue_input.txt */
// test op tag src1_ready src1_word src2_ready src2_word expected
// op: 0 add, 1 sub, 2 and, 3 xor, 4 mul; a waiting word holds the producer tag
0002 0000 0001 0001 1234 0001 4321 5555
0002 0001 0002 0001 0005 0001 0007 fffe
0002 0002 0003 0001 f0f0 0001 3c3c 3030
0002 0003 0004 0001 ffff 0001 8001 7ffe
0002 0000 0005 0001 ffff 0001 0002 0001
0003 0004 0001 0001 0003 0001 0007 0015
0003 0004 0002 0001 0100 0001 0100 0000
0003 0004 0003 0001 1234 0001 0010 2340
0003 0004 0004 0001 ffff 0001 ffff 0001
0003 0004 0005 0001 00ff 0001 0101 ffff
0004 0000 0001 0001 000a 0001 0014 001e
0004 0004 0002 0000 0001 0001 0007 00d2
0004 0001 0003 0000 0002 0000 0001 00b4
0004 0003 0004 0000 0003 0000 0002 0066
0005 0004 0001 0001 0003 0001 0005 000f
0005 0004 0002 0001 0006 0001 0007 002a
0005 0000 0003 0001 0001 0001 0001 0002
0005 0002 0004 0001 00ff 0001 0f0f 000f
0006 0004 0001 0001 0003 0001 0005 000f
0006 0000 0002 0000 0001 0001 0001 0010
0006 0001 0003 0000 0001 0001 0002 000d
0006 0002 0004 0000 0001 0001 0007 0007
0006 0003 0005 0000 0001 0001 00ff 00f0
0006 0000 0006 0001 0001 0001 0002 0003

/* verilog.f */
logic/ooo_pkg.sv
logic/fu_issue_if.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/mult_unit.sv
logic/cdb_arbiter.sv
logic/issue_core.sv
dv/issue_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the issue_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
  --top-module issue_core_tb -o issue_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/issue_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1
